/* armCtrl.f */
logic/armCtrlPkg.sv
logic/decodeStage.sv
logic/condUnit.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/armController.sv
verif/armControllerTb.sv

/* logic/armController.sv */
`default_nettype none
`timescale 1ns/10ps

module armController (
  input  logic                   clk,
  input  logic                   reset,
  input  armCtrlPkg::instrT      instrD,
  input  armCtrlPkg::flagsT      aluFlagsE,
  input  armCtrlPkg::byteOffsetT aluAddrE,
  input  logic                   stallE,
  input  logic                   flushE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   flushW,
  output armCtrlPkg::srcSelT     regSrcD,
  output armCtrlPkg::srcSelT     immSrcD,
  output armCtrlPkg::aluCtrlT    aluControlE,
  output logic                   aluSrcE,
  output logic                   branchTakenE,
  output armCtrlPkg::flagsT      flagsE,
  output logic                   memWriteM,
  output armCtrlPkg::byteMaskT   byteMaskM,
  output logic                   regWriteM,
  output logic                   memToRegW,
  output logic                   regWriteW,
  output logic                   pcSrcW,
  output logic                   pcWrPendingF
);
  import armCtrlPkg::*;

  logic       pcSrcD;
  flagWriteT  flagWriteE;
  condT       condE;
  logic       branchE;
  logic       regWriteE;
  logic       memWriteE;
  logic       memToRegE;
  logic       pcSrcE;
  logic       byteE;
  logic [1:0] instrClassE;
  logic       memToRegM;
  logic       pcSrcM;

  // ======================================
  // Stage instances
  // ======================================
  decodeStage i_decodeStage (
    .clk(clk), .reset(reset), .instrD(instrD), .stallE(stallE), .flushE(flushE),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .pcSrcD(pcSrcD),
    .aluControlE(aluControlE), .aluSrcE(aluSrcE), .flagWriteE(flagWriteE),
    .condE(condE), .branchE(branchE), .regWriteE(regWriteE), .memWriteE(memWriteE),
    .memToRegE(memToRegE), .pcSrcE(pcSrcE), .byteE(byteE), .instrClassE(instrClassE)
  );

  executeStage i_executeStage (
    .clk(clk), .reset(reset), .flagWriteE(flagWriteE), .condE(condE),
    .branchE(branchE), .regWriteE(regWriteE), .memWriteE(memWriteE),
    .memToRegE(memToRegE), .pcSrcE(pcSrcE), .byteE(byteE), .instrClassE(instrClassE),
    .aluFlagsE(aluFlagsE), .aluAddrE(aluAddrE), .stallE(stallE), .stallM(stallM),
    .branchTakenE(branchTakenE), .flagsE(flagsE), .regWriteM(regWriteM),
    .memWriteM(memWriteM), .memToRegM(memToRegM), .pcSrcM(pcSrcM), .byteMaskM(byteMaskM)
  );

  memWbStage i_memWbStage (
    .clk(clk), .reset(reset), .regWriteM(regWriteM), .memToRegM(memToRegM),
    .pcSrcM(pcSrcM), .pcSrcD(pcSrcD), .pcSrcE(pcSrcE), .stallW(stallW), .flushW(flushW),
    .regWriteW(regWriteW), .memToRegW(memToRegW), .pcSrcW(pcSrcW),
    .pcWrPendingF(pcWrPendingF)
  );

endmodule

`default_nettype wire

/* logic/armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  // ======================================
  // Field and control widths
  // ======================================
  typedef logic [31:0] instrT;      // Full instruction word
  typedef logic [3:0]  condT;       // Condition field, bits 31:28
  typedef logic [3:0]  flagsT;      // N Z C V, N on top
  typedef logic [3:0]  aluCtrlT;    // Same coding as the DP cmd field
  typedef logic [1:0]  flagWriteT;  // [1] updates NZ, [0] updates CV
  typedef logic [3:0]  byteMaskT;   // One bit per byte lane
  typedef logic [1:0]  byteOffsetT; // Low address bits
  typedef logic [1:0]  srcSelT;     // regSrc and immSrc selects

  // ======================================
  // ALU operations used outside data processing
  // ======================================
  localparam aluCtrlT ALU_ADD = 4'b0100;
  localparam aluCtrlT ALU_SUB = 4'b0010;

  // Instruction classes from op field, bits 27:26
  // op 11 is not implemented and decodes as a no-op
  localparam logic [1:0] OP_DATA   = 2'b00;
  localparam logic [1:0] OP_MEM    = 2'b01;
  localparam logic [1:0] OP_BRANCH = 2'b10;

  // Source select encodings
  localparam srcSelT REG_SRC_DEFAULT = 2'b00;
  localparam srcSelT REG_SRC_PC      = 2'b01; // Branch reads R15 as Rn
  localparam srcSelT REG_SRC_STORE   = 2'b10; // Store reads Rd as second source

  localparam srcSelT IMM_SRC_DP     = 2'b00;  // 8-bit rotated immediate
  localparam srcSelT IMM_SRC_MEM    = 2'b01;  // 12-bit offset
  localparam srcSelT IMM_SRC_BRANCH = 2'b10;  // 24-bit word offset

  // Flag update selects for data processing
  localparam flagWriteT FLAGS_NONE = 2'b00;
  localparam flagWriteT FLAGS_NZ   = 2'b10;
  localparam flagWriteT FLAGS_ALL  = 2'b11;

endpackage

`default_nettype wire

/* logic/condUnit.sv */
`default_nettype none
`timescale 1ns/10ps

module condUnit (
  input  logic                  clk,
  input  logic                  reset,
  input  armCtrlPkg::condT      condE,
  input  armCtrlPkg::flagWriteT flagWriteE,
  input  armCtrlPkg::flagsT     aluFlagsE,
  input  logic                  stallE,
  output logic                  condExE,
  output armCtrlPkg::flagsT     flagsE
);

  logic negFlag;
  logic zeroFlag;
  logic carryFlag;
  logic ovfFlag;
  logic geFlag;

  assign {negFlag, zeroFlag, carryFlag, ovfFlag} = flagsE;
  assign geFlag = (negFlag == ovfFlag);  // Signed greater or equal

  // ======================================
  // Condition check against stored flags
  // ======================================
  always_comb begin
    case (condE)
      4'b0000: condExE = zeroFlag;                // EQ
      4'b0001: condExE = ~zeroFlag;               // NE
      4'b0010: condExE = carryFlag;               // CS
      4'b0011: condExE = ~carryFlag;              // CC
      4'b0100: condExE = negFlag;                 // MI
      4'b0101: condExE = ~negFlag;                // PL
      4'b0110: condExE = ovfFlag;                 // VS
      4'b0111: condExE = ~ovfFlag;                // VC
      4'b1000: condExE = carryFlag & ~zeroFlag;   // HI
      4'b1001: condExE = ~carryFlag | zeroFlag;   // LS
      4'b1010: condExE = geFlag;                  // GE
      4'b1011: condExE = ~geFlag;                 // LT
      4'b1100: condExE = ~zeroFlag & geFlag;      // GT
      4'b1101: condExE = zeroFlag | ~geFlag;      // LE
      4'b1110: condExE = 1'b1;                    // AL
      default: condExE = 1'b0;                    // 1111 never passes
    endcase
  end

  // NZ and CV load independently, only for a passing instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      flagsE <= '0;
    end else if (!stallE && condExE) begin
      if (flagWriteE[1])
        flagsE[3:2] <= aluFlagsE[3:2];
      if (flagWriteE[0])
        flagsE[1:0] <= aluFlagsE[1:0];
    end
  end

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`default_nettype none
`timescale 1ns/10ps

module decodeStage (
  input  logic                  clk,
  input  logic                  reset,
  input  armCtrlPkg::instrT     instrD,
  input  logic                  stallE,
  input  logic                  flushE,
  output armCtrlPkg::srcSelT    regSrcD,
  output armCtrlPkg::srcSelT    immSrcD,
  output logic                  pcSrcD,
  output armCtrlPkg::aluCtrlT   aluControlE,
  output logic                  aluSrcE,
  output armCtrlPkg::flagWriteT flagWriteE,
  output armCtrlPkg::condT      condE,
  output logic                  branchE,
  output logic                  regWriteE,
  output logic                  memWriteE,
  output logic                  memToRegE,
  output logic                  pcSrcE,
  output logic                  byteE,
  output logic [1:0]            instrClassE
);
  import armCtrlPkg::*;

  logic [1:0] opD;
  aluCtrlT    cmdD;
  logic [3:0] rdD;
  logic       immBitD;
  logic       sBitD;
  logic       upBitD;
  logic       byteBitD;
  logic       loadBitD;
  logic       logicalD;

  aluCtrlT    aluControlD;
  logic       aluSrcD;
  flagWriteT  flagWriteD;
  logic       regWriteD;
  logic       memWriteD;
  logic       memToRegD;
  logic       branchD;
  logic       byteD;

  // Instruction fields
  assign opD      = instrD[27:26];
  assign immBitD  = instrD[25];
  assign cmdD     = instrD[24:21];
  assign upBitD   = instrD[23];   // Memory offset direction
  assign byteBitD = instrD[22];
  assign sBitD    = instrD[20];   // Also the L bit for memory
  assign loadBitD = instrD[20];
  assign rdD      = instrD[15:12];

  // AND EOR TST TEQ and ORR MOV BIC MVN leave C and V alone
  assign logicalD = (cmdD[2:1] == 2'b00) | (cmdD[3:2] == 2'b11);

  // ======================================
  // Main and ALU decoder
  // ======================================
  always_comb begin
    regSrcD     = REG_SRC_DEFAULT;
    immSrcD     = IMM_SRC_DP;
    aluSrcD     = 1'b0;
    aluControlD = ALU_ADD;
    flagWriteD  = FLAGS_NONE;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    memToRegD   = 1'b0;
    branchD     = 1'b0;
    byteD       = 1'b0;
    case (opD)
      OP_DATA: begin
        aluSrcD     = immBitD;
        aluControlD = cmdD;
        regWriteD   = (cmdD[3:2] != 2'b10); // No write for TST TEQ CMP CMN
        if (sBitD)
          flagWriteD = logicalD ? FLAGS_NZ : FLAGS_ALL;
      end
      OP_MEM: begin
        regSrcD     = loadBitD ? REG_SRC_DEFAULT : REG_SRC_STORE;
        immSrcD     = IMM_SRC_MEM;
        aluSrcD     = ~immBitD;     // I clear means immediate offset
        aluControlD = upBitD ? ALU_ADD : ALU_SUB;
        regWriteD   = loadBitD;
        memToRegD   = loadBitD;
        memWriteD   = ~loadBitD;
        byteD       = byteBitD;
      end
      OP_BRANCH: begin
        regSrcD = REG_SRC_PC;
        immSrcD = IMM_SRC_BRANCH;
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: begin
        // op 11 stays a no-op with every write off
        branchD = 1'b0;
      end
    endcase
  end

  assign pcSrcD = ((rdD == 4'hF) & regWriteD) | branchD;

  // ======================================
  // Decode to execute register
  // ======================================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin  // Flush wins over stall
      aluControlE <= '0;
      aluSrcE     <= 1'b0;
      flagWriteE  <= '0;
      condE       <= '0;
      branchE     <= 1'b0;
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memToRegE   <= 1'b0;
      pcSrcE      <= 1'b0;
      byteE       <= 1'b0;
      instrClassE <= '0;
    end else if (!stallE) begin
      aluControlE <= aluControlD;
      aluSrcE     <= aluSrcD;
      flagWriteE  <= flagWriteD;
      condE       <= instrD[31:28];
      branchE     <= branchD;
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      memToRegE   <= memToRegD;
      pcSrcE      <= pcSrcD;
      byteE       <= byteD;
      instrClassE <= opD;
    end
  end

  // Fetch hands over a known word every cycle
  instrKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(instrD));

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`default_nettype none
`timescale 1ns/10ps

module executeStage (
  input  logic                   clk,
  input  logic                   reset,
  input  armCtrlPkg::flagWriteT  flagWriteE,
  input  armCtrlPkg::condT       condE,
  input  logic                   branchE,
  input  logic                   regWriteE,
  input  logic                   memWriteE,
  input  logic                   memToRegE,
  input  logic                   pcSrcE,
  input  logic                   byteE,
  input  logic [1:0]             instrClassE,
  input  armCtrlPkg::flagsT      aluFlagsE,
  input  armCtrlPkg::byteOffsetT aluAddrE,
  input  logic                   stallE,
  input  logic                   stallM,
  output logic                   branchTakenE,
  output armCtrlPkg::flagsT      flagsE,
  output logic                   regWriteM,
  output logic                   memWriteM,
  output logic                   memToRegM,
  output logic                   pcSrcM,
  output armCtrlPkg::byteMaskT   byteMaskM
);
  import armCtrlPkg::*;

  logic     condExE;
  logic     regWriteGatedE;
  logic     memWriteGatedE;
  logic     pcSrcGatedE;
  byteMaskT byteMaskE;

  condUnit i_condUnit (
    .clk        (clk),
    .reset      (reset),
    .condE      (condE),
    .flagWriteE (flagWriteE),
    .aluFlagsE  (aluFlagsE),
    .stallE     (stallE),
    .condExE    (condExE),
    .flagsE     (flagsE)
  );

  // ======================================
  // Condition gating
  // ======================================
  assign branchTakenE   = branchE & condExE;
  assign regWriteGatedE = regWriteE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE;

  // Lane select for the data memory
  always_comb begin
    if (instrClassE != OP_MEM)
      byteMaskE = 4'b0000;              // No transfer
    else if (byteE)
      byteMaskE = 4'b0001 << aluAddrE;  // Single lane
    else
      byteMaskE = 4'b1111;              // Whole word
  end

  // ======================================
  // Execute to memory register
  // ======================================
  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      byteMaskM <= '0;
    end else if (!stallM) begin
      regWriteM <= regWriteGatedE;
      memWriteM <= memWriteGatedE;
      memToRegM <= memToRegE;
      pcSrcM    <= pcSrcGatedE;
      byteMaskM <= byteMaskE;
    end
  end

  // Datapath supplies a known lane for byte transfers
  byteAddrKnown: assert property (@(posedge clk) disable iff (reset)
    byteE |-> !$isunknown(aluAddrE));

endmodule

`default_nettype wire

/* logic/memWbStage.sv */
`default_nettype none
`timescale 1ns/10ps

module memWbStage (
  input  logic clk,
  input  logic reset,
  input  logic regWriteM,
  input  logic memToRegM,
  input  logic pcSrcM,
  input  logic pcSrcD,
  input  logic pcSrcE,
  input  logic stallW,
  input  logic flushW,
  output logic regWriteW,
  output logic memToRegW,
  output logic pcSrcW,
  output logic pcWrPendingF
);

  // ======================================
  // Memory to writeback register
  // ======================================
  always_ff @(posedge clk) begin
    if (reset || flushW) begin  // Flush wins over stall
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else if (!stallW) begin
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
      pcSrcW    <= pcSrcM;
    end
  end

  // Any PC write still in flight holds off fetch
  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;

endmodule

`default_nettype wire

/* verif/armControllerTb.sv */
`default_nettype none
`timescale 1ns/10ps

module armControllerTb;
  import armCtrlPkg::*;

  localparam instrT NOP         = 32'hEC00_0000; // op 11 decodes to nothing
  localparam condT  COND_AL     = 4'hE;
  localparam int    CYCLE_LIMIT = 400;           // About 170 cycles of tests plus margin

  logic       clk = 1'b0;
  logic       reset;
  instrT      instrD;
  flagsT      aluFlagsE;
  byteOffsetT aluAddrE;
  logic       stallE;
  logic       flushE;
  logic       stallM;
  logic       stallW;
  logic       flushW;
  srcSelT     regSrcD;
  srcSelT     immSrcD;
  aluCtrlT    aluControlE;
  logic       aluSrcE;
  logic       branchTakenE;
  flagsT      flagsE;
  logic       memWriteM;
  byteMaskT   byteMaskM;
  logic       regWriteM;
  logic       memToRegW;
  logic       regWriteW;
  logic       pcSrcW;
  logic       pcWrPendingF;

  int     errorCount;
  int     testsPassed;
  int     testsFailed;
  int     cycleCount = 0;
  integer seed;
  flagsT  modelFlags;   // Reference NZCV
  instrT  pipeInstrE;   // Instruction the model sees in execute

  armController i_armController (
    .clk(clk), .reset(reset), .instrD(instrD), .aluFlagsE(aluFlagsE), .aluAddrE(aluAddrE),
    .stallE(stallE), .flushE(flushE), .stallM(stallM), .stallW(stallW), .flushW(flushW),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluControlE(aluControlE), .aluSrcE(aluSrcE),
    .branchTakenE(branchTakenE), .flagsE(flagsE), .memWriteM(memWriteM),
    .byteMaskM(byteMaskM), .regWriteM(regWriteM), .memToRegW(memToRegW),
    .regWriteW(regWriteW), .pcSrcW(pcSrcW), .pcWrPendingF(pcWrPendingF)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycleCount);
      $display("Something failed");
      $finish;
    end
  end

  // ========================================
  // Instruction encoders and reference rules
  // ========================================
  function automatic instrT encodeDp(input condT cond, input logic imm, input aluCtrlT cmd,
                                     input logic s, input logic [3:0] rd);
    return {cond, 2'b00, imm, cmd, s, 4'd2, rd, 12'h005};
  endfunction

  function automatic instrT encodeMem(input logic up, input logic byteBit, input logic load);
    return {COND_AL, 2'b01, 1'b0, 1'b1, up, byteBit, 1'b0, load, 4'd3, 4'd4, 12'h008};
  endfunction

  function automatic instrT encodeBranch(input condT cond);
    return {cond, 3'b101, 1'b0, 24'h000010};
  endfunction

  // Base test from cond[3:1] and cond[0] inverts it
  function automatic logic conditionHolds(input condT cond, input flagsT flags);
    logic n;
    logic z;
    logic c;
    logic v;
    logic base;
    {n, z, c, v} = flags;
    case (cond[3:1])
      3'b000:  base = z;
      3'b001:  base = c;
      3'b010:  base = n;
      3'b011:  base = v;
      3'b100:  base = c && !z;
      3'b101:  base = (n == v);
      3'b110:  base = !z && (n == v);
      default: base = 1'b1;
    endcase
    return cond[0] ? !base : base;
  endfunction

  function automatic flagWriteT flagUpdateOf(input instrT instr);
    aluCtrlT cmd;
    cmd = instr[24:21];
    if (instr[27:26] != 2'b00 || !instr[20])
      return 2'b00;
    case (cmd)
      4'b0000, 4'b0001, 4'b1000, 4'b1001,
      4'b1100, 4'b1101, 4'b1110, 4'b1111: return 2'b10;  // Logical ops update NZ only
      default: return 2'b11;
    endcase
  endfunction

  // Flag model follows the instruction that sits in execute
  always @(posedge clk) begin : flagModel
    flagWriteT upd;
    upd = flagUpdateOf(pipeInstrE);
    if (reset) begin
      modelFlags <= '0;
      pipeInstrE <= NOP;
    end else begin
      if (!stallE && conditionHolds(pipeInstrE[31:28], modelFlags)) begin
        if (upd[1]) modelFlags[3:2] <= aluFlagsE[3:2];
        if (upd[0]) modelFlags[1:0] <= aluFlagsE[1:0];
      end
      if (flushE)
        pipeInstrE <= NOP;
      else if (!stallE)
        pipeInstrE <= instrD;
    end
  end

  // ========================================
  // Compare and pacing tasks
  // ========================================
  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expVal, actVal);
    end
  endtask

  task automatic checkFlags(input string name, input flagsT expVal, input flagsT actVal);
    if (actVal !== expVal) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expVal, actVal);
    end
  endtask

  task automatic checkAluCtrl(input string name, input aluCtrlT expVal, input aluCtrlT actVal);
    if (actVal !== expVal) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
    end
  endtask

  task automatic checkMask(input string name, input byteMaskT expVal, input byteMaskT actVal);
    if (actVal !== expVal) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expVal, actVal);
    end
  endtask

  task automatic checkSrcSel(input string name, input srcSelT expVal, input srcSelT actVal);
    if (actVal !== expVal) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expVal, actVal);
    end
  endtask

  task automatic advanceCycle();
    @(posedge clk);
    #10;
  endtask

  task automatic reportTest(input string name, input int startErrors);
    if (errorCount == startErrors) begin
      testsPassed++;
      $display("Test %s: ok", name);
    end else begin
      testsFailed++;
      $display("Test %s: %0d mismatches", name, errorCount - startErrors);
    end
  endtask

  task automatic drainPipe();
    instrD = NOP;
    repeat (3) advanceCycle();
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic resetState();
    int startErrors;
    startErrors = errorCount;
    repeat (10) @(posedge clk);
    #10;
    reset = 1'b0;
    checkBit("regWriteM", 1'b0, regWriteM);
    checkBit("regWriteW", 1'b0, regWriteW);
    checkBit("memWriteM", 1'b0, memWriteM);
    checkBit("pcSrcW", 1'b0, pcSrcW);
    checkBit("branchTakenE", 1'b0, branchTakenE);
    checkBit("pcWrPendingF", 1'b0, pcWrPendingF);
    checkFlags("flagsE", 4'b0000, flagsE);
    reportTest("reset", startErrors);
  endtask

  task automatic dataProcessing();
    int startErrors;
    startErrors = errorCount;
    instrD = encodeDp(COND_AL, 1'b1, 4'b0100, 1'b0, 4'd1);   // ADD r1, r2, #5
    #1;
    checkSrcSel("regSrcD", REG_SRC_DEFAULT, regSrcD);
    checkSrcSel("immSrcD", IMM_SRC_DP, immSrcD);
    advanceCycle();
    checkAluCtrl("aluControlE", 4'b0100, aluControlE);
    checkBit("aluSrcE", 1'b1, aluSrcE);
    instrD = encodeDp(COND_AL, 1'b0, 4'b1010, 1'b1, 4'd0);   // CMP r2, r5
    advanceCycle();
    checkAluCtrl("aluControlE", 4'b1010, aluControlE);
    checkBit("aluSrcE", 1'b0, aluSrcE);
    checkBit("regWriteW", 1'b0, regWriteW);
    instrD = NOP;
    advanceCycle();
    checkBit("regWriteW", 1'b1, regWriteW);                 // ADD reaches writeback
    advanceCycle();
    checkBit("regWriteW", 1'b0, regWriteW);                 // CMP writes no register
    instrD = encodeDp(COND_AL, 1'b1, 4'b0100, 1'b0, 4'd15);  // ADD pc
    #1 checkBit("pcWrPendingF", 1'b1, pcWrPendingF);
    advanceCycle();
    instrD = NOP;
    #1 checkBit("pcWrPendingF", 1'b1, pcWrPendingF);
    advanceCycle();
    checkBit("pcWrPendingF", 1'b1, pcWrPendingF);
    advanceCycle();
    checkBit("pcWrPendingF", 1'b0, pcWrPendingF);
    checkBit("pcSrcW", 1'b1, pcSrcW);
    drainPipe();
    reportTest("data processing", startErrors);
  endtask

  task automatic setFlags(input instrT instr, input flagsT aluFlags);
    instrD = instr;
    advanceCycle();
    aluFlagsE = aluFlags;
    instrD = NOP;
    advanceCycle();
    aluFlagsE = '0;
    checkFlags("flagsE", modelFlags, flagsE);
  endtask

  // Branch then ADD for each code with checks in E and M
  task automatic sweepConditions();
    condT cond;
    logic prevExp;
    for (int i = 0; i < 16; i++) begin
      cond = condT'(i);
      instrD = encodeBranch(cond);
      advanceCycle();
      checkBit("branchTakenE", conditionHolds(cond, modelFlags), branchTakenE);
      if (i > 0)
        checkBit("regWriteM", prevExp, regWriteM);
      instrD = encodeDp(cond, 1'b1, 4'b0100, 1'b0, 4'd1);
      advanceCycle();
      prevExp = conditionHolds(cond, modelFlags);
    end
    instrD = NOP;
    advanceCycle();
    checkBit("regWriteM", prevExp, regWriteM);
  endtask

  task automatic conditionCodes();
    int startErrors;
    startErrors = errorCount;
    setFlags(encodeDp(COND_AL, 1'b0, 4'b0100, 1'b1, 4'd1), 4'b1001);  // ADDS sets N and V
    sweepConditions();
    setFlags(encodeDp(COND_AL, 1'b0, 4'b1010, 1'b1, 4'd0), 4'b0110);  // CMP sets Z and C
    sweepConditions();
    setFlags(encodeDp(COND_AL, 1'b0, 4'b0000, 1'b1, 4'd1), 4'b1001);  // ANDS
    checkFlags("flagsE", 4'b1010, flagsE);                            // C and V kept
    sweepConditions();
    reportTest("conditions", startErrors);
  endtask

  task automatic memoryTransfers();
    int         startErrors;
    integer     randomWord;
    logic [2:0] mode;
    byteMaskT   expMask;
    startErrors = errorCount;
    for (int i = 0; i < 8; i++) begin
      mode = i[2:0];                               // {up, byte, load}
      randomWord = $random(seed);
      instrD = encodeMem(mode[2], mode[1], mode[0]);
      #1;
      checkSrcSel("regSrcD", mode[0] ? REG_SRC_DEFAULT : REG_SRC_STORE, regSrcD);
      checkSrcSel("immSrcD", IMM_SRC_MEM, immSrcD);
      advanceCycle();
      checkAluCtrl("aluControlE", mode[2] ? ALU_ADD : ALU_SUB, aluControlE);
      checkBit("aluSrcE", 1'b1, aluSrcE);
      aluAddrE = randomWord[1:0];
      instrD = NOP;
      advanceCycle();
      if (mode[1]) begin
        expMask = '0;
        expMask[aluAddrE] = 1'b1;
      end else begin
        expMask = 4'b1111;
      end
      checkMask("byteMaskM", expMask, byteMaskM);
      checkBit("memWriteM", !mode[0], memWriteM);
      advanceCycle();
      checkBit("memToRegW", mode[0], memToRegW);
    end
    reportTest("memory", startErrors);
  endtask

  task automatic runBranch(input condT cond, input logic expTaken);
    instrD = encodeBranch(cond);
    #1;
    checkSrcSel("regSrcD", REG_SRC_PC, regSrcD);
    checkSrcSel("immSrcD", IMM_SRC_BRANCH, immSrcD);
    advanceCycle();
    checkBit("branchTakenE", expTaken, branchTakenE);
    instrD = NOP;
    advanceCycle();
    advanceCycle();
    checkBit("pcSrcW", expTaken, pcSrcW);
    advanceCycle();
  endtask

  task automatic branchOutcome();
    int   startErrors;
    condT failCond;
    startErrors = errorCount;
    failCond = conditionHolds(4'b0000, modelFlags) ? 4'b0001 : 4'b0000;
    runBranch(COND_AL, 1'b1);
    runBranch(failCond, 1'b0);
    reportTest("branch", startErrors);
  endtask

  task automatic stallAndFlush();
    int startErrors;
    startErrors = errorCount;
    instrD = encodeDp(COND_AL, 1'b0, 4'b0100, 1'b0, 4'd1);
    advanceCycle();
    checkAluCtrl("aluControlE", 4'b0100, aluControlE);
    stallE = 1'b1;
    instrD = encodeDp(COND_AL, 1'b0, 4'b0010, 1'b0, 4'd1);  // SUB waits in decode
    repeat (2) begin
      advanceCycle();
      checkAluCtrl("aluControlE", 4'b0100, aluControlE);
    end
    stallE = 1'b0;
    advanceCycle();
    checkAluCtrl("aluControlE", 4'b0010, aluControlE);
    // Bubble in place of an ADD
    instrD = encodeDp(COND_AL, 1'b0, 4'b0100, 1'b0, 4'd1);
    flushE = 1'b1;
    advanceCycle();
    flushE = 1'b0;
    instrD = NOP;
    advanceCycle();
    checkBit("regWriteM", 1'b0, regWriteM);
    instrD = encodeDp(COND_AL, 1'b0, 4'b0100, 1'b0, 4'd1);
    advanceCycle();
    instrD = NOP;
    advanceCycle();
    checkBit("regWriteM", 1'b1, regWriteM);
    flushW = 1'b1;
    advanceCycle();
    flushW = 1'b0;
    checkBit("regWriteW", 1'b0, regWriteW);
    drainPipe();
    reportTest("stall and flush", startErrors);
  endtask

  initial begin
    seed        = 8;
    errorCount  = 0;
    testsPassed = 0;
    testsFailed = 0;
    reset       = 1'b1;
    instrD      = NOP;
    aluFlagsE   = '0;
    aluAddrE    = '0;
    stallE      = 1'b0;
    flushE      = 1'b0;
    stallM      = 1'b0;
    stallW      = 1'b0;
    flushW      = 1'b0;
    resetState();
    dataProcessing();
    conditionCodes();
    memoryTransfers();
    branchOutcome();
    stallAndFlush();
    $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
             testsPassed, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
